// ==== rtl/isaPkg.sv ====
package isaPkg;

    // Data and address width of the machine
    localparam int wordWidth = 16;

    typedef logic [wordWidth-1:0] wordT;

    localparam int regIdxWidth = 3;          // Eight architectural registers

    typedef logic [regIdxWidth-1:0] regIdxT;

    localparam regIdxT zeroReg = 3'd0;       // Always reads zero
    localparam regIdxT linkReg = 3'd7;       // Return address register

    // Instruction word layout
    localparam int opcodeHi = 15;
    localparam int opcodeLo = 12;

    localparam int rxHi = 11;                // Destination / second source
    localparam int rxLo = 9;
    localparam int ryHi = 8;                 // First source
    localparam int ryLo = 6;
    localparam int rzHi = 5;                 // Alternate second source
    localparam int rzLo = 3;

    localparam int immHi = 7;                // Overlaps rz on I-type
    localparam int immLo = 0;
    localparam int immWidth = immHi - immLo + 1;

    localparam int jumpHi = 11;              // J-type absolute field
    localparam int jumpLo = 0;
    localparam int jumpWidth = jumpHi - jumpLo + 1;

endpackage

// ==== rtl/ctrlPkg.sv ====
package ctrlPkg;

    // Operand source chosen by the forwarding unit
    typedef enum logic [1:0] {
        fwdReg = 2'b00,                      // Register file value
        fwdExe = 2'b01,                      // ALU result in execute
        fwdMem = 2'b10,                      // Writeback data in memory stage
        fwdWb  = 2'b11                       // Writeback data in writeback stage
    } fwdSelT;

    localparam int ctrlWidth = 6;

    // Decode control vector from the main decoder
    typedef logic [ctrlWidth-1:0] decodeCtrlT;

    localparam int src1SelHi    = 5;
    localparam int src1SelLo    = 4;
    localparam int src2SelBit   = 3;         // 1 picks rz, 0 picks rx
    localparam int regDstBit    = 2;         // 1 picks link register
    localparam int extSignedBit = 1;
    localparam int extUpperBit  = 0;         // Overrides extSigned

    // First source register selection
    localparam logic [1:0] src1Ry   = 2'b00;
    localparam logic [1:0] src1Zero = 2'b01;
    localparam logic [1:0] src1Link = 2'b10;
    localparam logic [1:0] src1Rsvd = 2'b11; // Treated as ry

endpackage

// ==== rtl/instFields.sv ====
`timescale 1ns/10ps

module instFields (
    input  isaPkg::wordT        inst,
    input  isaPkg::wordT        pc,
    input  ctrlPkg::decodeCtrlT ctrl,
    output isaPkg::regIdxT      ra,
    output isaPkg::regIdxT      rb,
    output isaPkg::regIdxT      rd,
    output isaPkg::wordT        immediate,
    output isaPkg::wordT        branchTarget,
    output isaPkg::wordT        jumpTarget
);

    import isaPkg::*;
    import ctrlPkg::*;

    localparam int fillWidth = wordWidth - immWidth;
    localparam wordT pcOffset = wordT'(2);   // PC already points past the branch

    logic [immWidth-1:0] immField;
    logic [1:0]          src1Sel;
    logic                signFill;

    assign immField = inst[immHi:immLo];
    assign src1Sel  = ctrl[src1SelHi:src1SelLo];

    // First source index
    always_comb begin
        case (src1Sel)
            src1Zero: ra = zeroReg;
            src1Link: ra = linkReg;          // Return through r7
            src1Ry,
            src1Rsvd: ra = inst[ryHi:ryLo];
            default:  ra = inst[ryHi:ryLo];
        endcase
    end

    assign rb = ctrl[src2SelBit] ? inst[rzHi:rzLo] : inst[rxHi:rxLo];
    assign rd = ctrl[regDstBit] ? linkReg : inst[rxHi:rxLo];

    assign signFill = ctrl[extSignedBit] & immField[immWidth-1];

    always_comb begin
        if (ctrl[extUpperBit]) begin
            immediate = {immField, {fillWidth{1'b0}}};  // Load-upper form
        end else begin
            immediate = {{fillWidth{signFill}}, immField};
        end
    end

    // Relative branch, wraps modulo the word size
    assign branchTarget = immediate + pc - pcOffset;

    // Absolute jump within the current 4K region
    assign jumpTarget = {pc[wordWidth-1:jumpWidth], inst[jumpHi:jumpLo]};

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/10ps

module regFile #(
    parameter int dataWidth = isaPkg::wordWidth
) (
    input  logic                 clk,
    input  logic                 reset,
    input  isaPkg::regIdxT       ra,
    input  isaPkg::regIdxT       rb,
    input  isaPkg::regIdxT       writeReg,
    input  logic                 regWrite,
    input  logic [dataWidth-1:0] writeData,
    output logic [dataWidth-1:0] busA,
    output logic [dataWidth-1:0] busB
);

    import isaPkg::*;

    localparam int numRegs = 2 ** $bits(regIdxT);

    logic [dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (writeReg != zeroReg)) begin
            regs[writeReg] <= writeData;     // r0 writes dropped
        end
    end

    // Reads see the old value during a same-cycle write
    assign busA = (ra == zeroReg) ? '0 : regs[ra];
    assign busB = (rb == zeroReg) ? '0 : regs[rb];

endmodule

// ==== rtl/operandForward.sv ====
`timescale 1ns/10ps

module operandForward #(
    parameter int dataWidth = isaPkg::wordWidth
) (
    input  logic [dataWidth-1:0] busA,
    input  logic [dataWidth-1:0] busB,
    input  logic [dataWidth-1:0] aluResultExe,
    input  logic [dataWidth-1:0] dataMem,
    input  logic [dataWidth-1:0] dataWb,
    input  ctrlPkg::fwdSelT      forwardA,
    input  ctrlPkg::fwdSelT      forwardB,
    output logic [dataWidth-1:0] valueA,
    output logic [dataWidth-1:0] valueB,
    output logic                 gt,
    output logic                 lt,
    output logic                 eq
);

    import ctrlPkg::*;

    function automatic logic [dataWidth-1:0] selectOperand(
        input fwdSelT               sel,
        input logic [dataWidth-1:0] regValue,
        input logic [dataWidth-1:0] exeValue,
        input logic [dataWidth-1:0] memValue,
        input logic [dataWidth-1:0] wbValue
    );
        case (sel)
            fwdExe:  return exeValue;
            fwdMem:  return memValue;
            fwdWb:   return wbValue;
            default: return regValue;
        endcase
    endfunction

    logic signed [dataWidth-1:0] signedA;
    logic signed [dataWidth-1:0] signedB;

    assign valueA = selectOperand(forwardA, busA, aluResultExe, dataMem, dataWb);
    assign valueB = selectOperand(forwardB, busB, aluResultExe, dataMem, dataWb);

    assign signedA = valueA;
    assign signedB = valueB;

    // Early branch resolution flags
    assign eq = (valueA == valueB);
    assign lt = (signedA < signedB);
    assign gt = (signedA > signedB);

endmodule

// ==== rtl/decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage (
    input  logic                clk,
    input  logic                reset,
    input  logic                regWrite,
    input  ctrlPkg::decodeCtrlT ctrl,
    input  ctrlPkg::fwdSelT     forwardA,
    input  ctrlPkg::fwdSelT     forwardB,
    input  isaPkg::wordT        inst,
    input  isaPkg::wordT        pc,
    input  isaPkg::wordT        aluResultExe,
    input  isaPkg::wordT        dataMem,
    input  isaPkg::wordT        dataWb,
    input  isaPkg::regIdxT      writeReg,
    output isaPkg::regIdxT      ra,
    output isaPkg::regIdxT      rb,
    output isaPkg::regIdxT      rd,
    output isaPkg::wordT        valueA,
    output isaPkg::wordT        valueB,
    output isaPkg::wordT        immediate,
    output isaPkg::wordT        branchTarget,
    output isaPkg::wordT        jumpTarget,
    output isaPkg::wordT        returnAddress,
    output logic                gt,
    output logic                lt,
    output logic                eq
);

    import isaPkg::*;

    logic [wordWidth-1:0] busA;              // Raw register reads
    logic [wordWidth-1:0] busB;

    // Index selection, immediate and targets
    instFields fields (
        .inst         (inst),
        .pc           (pc),
        .ctrl         (ctrl),
        .ra           (ra),
        .rb           (rb),
        .rd           (rd),
        .immediate    (immediate),
        .branchTarget (branchTarget),
        .jumpTarget   (jumpTarget)
    );

    regFile #(
        .dataWidth (wordWidth)
    ) regs (
        .clk       (clk),
        .reset     (reset),
        .ra        (ra),
        .rb        (rb),
        .writeReg  (writeReg),
        .regWrite  (regWrite),
        .writeData (dataWb),                 // Write port from writeback stage
        .busA      (busA),
        .busB      (busB)
    );

    // Bypass network and comparator
    operandForward #(
        .dataWidth (wordWidth)
    ) forward (
        .busA         (busA),
        .busB         (busB),
        .aluResultExe (aluResultExe),
        .dataMem      (dataMem),
        .dataWb       (dataWb),              // Covers the same-cycle write
        .forwardA     (forwardA),
        .forwardB     (forwardB),
        .valueA       (valueA),
        .valueB       (valueB),
        .gt           (gt),
        .lt           (lt),
        .eq           (eq)
    );

    assign returnAddress = valueA;           // Jump-register source

endmodule

// ==== bench/decodeStage_props.sv ====
`timescale 1ns/10ps

module decodeStageProps (
    input logic            clk,
    input logic            reset,
    input isaPkg::regIdxT  ra,
    input ctrlPkg::fwdSelT forwardA,
    input isaPkg::wordT    valueA,
    input isaPkg::wordT    returnAddress,
    input logic            gt,
    input logic            lt,
    input logic            eq
);

    import isaPkg::*;
    import ctrlPkg::*;

    flagsOneHot: assert property (@(posedge clk) disable iff (reset) $onehot({gt, lt, eq}))
        else $error("compare flags are not one-hot");

    returnFollowsA: assert property (@(posedge clk) returnAddress == valueA)
        else $error("returnAddress differs from valueA");

    // r0 read straight from the register file
    zeroRegReads: assert property (@(posedge clk) disable iff (reset)
        (ra == zeroReg && forwardA == fwdReg) |-> valueA == '0)
        else $error("valueA is not zero for register 0");

endmodule

bind decodeStage decodeStageProps props (
    .clk           (clk),
    .reset         (reset),
    .ra            (ra),
    .forwardA      (forwardA),
    .valueA        (valueA),
    .returnAddress (returnAddress),
    .gt            (gt),
    .lt            (lt),
    .eq            (eq)
);

// ==== bench/decodeStageTb.sv ====
`timescale 1ns/10ps

module decodeStageTb;

    import isaPkg::*;
    import ctrlPkg::*;

    localparam int halfPeriod     = 20;      // 40 ns clock
    localparam int compareTimeout = 4;       // Cycles to wait for one compare
    localparam int watchdogNs     = 100000;

    typedef struct packed {
        regIdxT ra;
        regIdxT rb;
        regIdxT rd;
        wordT   valueA;
        wordT   valueB;
        wordT   immediate;
        wordT   branchTarget;
        wordT   jumpTarget;
        wordT   returnAddress;
        logic   gt;
        logic   lt;
        logic   eq;
    } expectT;

    logic       clk;
    logic       reset;
    logic       regWrite;
    decodeCtrlT ctrl;
    fwdSelT     forwardA;
    fwdSelT     forwardB;
    wordT       inst;
    wordT       pc;
    wordT       aluResultExe;
    wordT       dataMem;
    wordT       dataWb;
    regIdxT     writeReg;

    regIdxT ra;
    regIdxT rb;
    regIdxT rd;
    wordT   valueA;
    wordT   valueB;
    wordT   immediate;
    wordT   branchTarget;
    wordT   jumpTarget;
    wordT   returnAddress;
    logic   gt;
    logic   lt;
    logic   eq;

    logic [7:0][15:0] modelRegs;             // Reference copy of the register file
    logic [31:0]      lfsrState = 32'hbace_1649;
    int               checksRequested = 0;
    int               checksDone = 0;

    decodeStage uut (
        .clk           (clk),
        .reset         (reset),
        .regWrite      (regWrite),
        .ctrl          (ctrl),
        .forwardA      (forwardA),
        .forwardB      (forwardB),
        .inst          (inst),
        .pc            (pc),
        .aluResultExe  (aluResultExe),
        .dataMem       (dataMem),
        .dataWb        (dataWb),
        .writeReg      (writeReg),
        .ra            (ra),
        .rb            (rb),
        .rd            (rd),
        .valueA        (valueA),
        .valueB        (valueB),
        .immediate     (immediate),
        .branchTarget  (branchTarget),
        .jumpTarget    (jumpTarget),
        .returnAddress (returnAddress),
        .gt            (gt),
        .lt            (lt),
        .eq            (eq)
    );

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // Register model follows the writes this bench requests
    always @(posedge clk) begin
        if (reset) begin
            modelRegs <= '0;
        end else if (regWrite && (writeReg != 3'd0)) begin
            modelRegs[writeReg] <= dataWb;
        end
    end

    function automatic logic [31:0] stepLfsr(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 32'h8020_0003;   // Taps 32, 22, 2, 1
        end
        return shifted;
    endfunction

    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = stepLfsr(lfsrState);
        end
        return value;
    endfunction

    function automatic wordT randomWord();
        logic [31:0] bits;
        bits = takeBits(16);
        return bits[15:0];
    endfunction

    function automatic regIdxT randomIndex();
        logic [31:0] bits;
        bits = takeBits(3);
        return bits[2:0];
    endfunction

    function automatic fwdSelT randomSelect();
        logic [31:0] bits;
        bits = takeBits(2);
        return fwdSelT'(bits[1:0]);
    endfunction

    function automatic decodeCtrlT randomCtrl();
        logic [31:0] bits;
        bits = takeBits(6);
        return bits[5:0];
    endfunction

    // Expected outputs straight from the decode rules
    function automatic expectT computeExpected(
        input wordT             instIn,
        input wordT             pcIn,
        input decodeCtrlT       ctrlIn,
        input fwdSelT           fwdA,
        input fwdSelT           fwdB,
        input wordT             exeIn,
        input wordT             memIn,
        input wordT             wbIn,
        input logic [7:0][15:0] regsIn
    );
        expectT     result;
        logic [7:0] imm8;
        wordT       biasedA;
        wordT       biasedB;
        wordT       sourcesA [4];
        wordT       sourcesB [4];
        case (ctrlIn[5:4])
            2'b01:   result.ra = 3'd0;
            2'b10:   result.ra = 3'd7;
            default: result.ra = instIn[8:6];    // ry, also for the reserved code
        endcase
        result.rb = ctrlIn[3] ? instIn[5:3] : instIn[11:9];
        result.rd = ctrlIn[2] ? 3'd7 : instIn[11:9];
        imm8 = instIn[7:0];
        if (ctrlIn[0]) begin
            result.immediate = {imm8, 8'h00};
        end else if (ctrlIn[1]) begin
            result.immediate = {{8{imm8[7]}}, imm8};
        end else begin
            result.immediate = {8'h00, imm8};
        end
        result.branchTarget = result.immediate + pcIn - 16'd2;
        result.jumpTarget = {pcIn[15:12], instIn[11:0]};
        sourcesA[0] = regsIn[result.ra];
        sourcesB[0] = regsIn[result.rb];
        sourcesA[1] = exeIn;
        sourcesB[1] = exeIn;
        sourcesA[2] = memIn;
        sourcesB[2] = memIn;
        sourcesA[3] = wbIn;
        sourcesB[3] = wbIn;
        result.valueA = sourcesA[fwdA];
        result.valueB = sourcesB[fwdB];
        result.returnAddress = result.valueA;
        // Flipping the sign bit turns a signed order into an unsigned one
        biasedA = result.valueA ^ 16'h8000;
        biasedB = result.valueB ^ 16'h8000;
        result.gt = biasedA > biasedB;
        result.lt = biasedA < biasedB;
        result.eq = biasedA == biasedB;
        return result;
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic expectField(input string name, input wordT expected, input wordT actual);
        assert (actual === expected) else begin
            failRun($sformatf("error %s expected 0x%h actual 0x%h", name, expected, actual));
        end
    endtask

    task automatic compareOutputs();
        expectT expected;
        expected = computeExpected(inst, pc, ctrl, forwardA, forwardB, aluResultExe,
                                   dataMem, dataWb, modelRegs);
        expectField("ra", {13'b0, expected.ra}, {13'b0, ra});
        expectField("rb", {13'b0, expected.rb}, {13'b0, rb});
        expectField("rd", {13'b0, expected.rd}, {13'b0, rd});
        expectField("valueA", expected.valueA, valueA);
        expectField("valueB", expected.valueB, valueB);
        expectField("immediate", expected.immediate, immediate);
        expectField("branchTarget", expected.branchTarget, branchTarget);
        expectField("jumpTarget", expected.jumpTarget, jumpTarget);
        expectField("returnAddress", expected.returnAddress, returnAddress);
        expectField("gt", {15'b0, expected.gt}, {15'b0, gt});
        expectField("lt", {15'b0, expected.lt}, {15'b0, lt});
        expectField("eq", {15'b0, expected.eq}, {15'b0, eq});
    endtask

    // Comparing process, samples just before the rising edge
    initial begin
        forever begin
            @(negedge clk);
            #(halfPeriod - 2);
            if (checksRequested > checksDone) begin
                compareOutputs();
                checksDone++;
            end
        end
    end

    initial begin
        #(watchdogNs);
        failRun("Simulation watchdog expired before the test finished");
    end

    task automatic scrambleInputs();
        regWrite = takeBits(1) == 32'd1;
        ctrl = randomCtrl();
        forwardA = randomSelect();
        forwardB = randomSelect();
        inst = randomWord();
        pc = randomWord();
        aluResultExe = randomWord();
        dataMem = randomWord();
        dataWb = randomWord();
        writeReg = randomIndex();
    endtask

    task automatic startCycle();
        @(negedge clk);
        scrambleInputs();                    // Callers override what they test
    endtask

    task automatic waitForCompare();
        int cycles;
        cycles = 0;
        while (checksDone < checksRequested && cycles < compareTimeout) begin
            @(posedge clk);
            cycles++;
        end
        if (checksDone < checksRequested) begin
            failRun("The compare process did not check the outputs in time");
        end
    endtask

    task automatic requestCheck();
        checksRequested++;
        waitForCompare();
    endtask

    task automatic resetReadback();
        for (int i = 0; i < 8; i++) begin
            startCycle();
            regWrite = 1'b0;
            forwardA = fwdReg;
            forwardB = fwdReg;
            ctrl[src1SelHi:src1SelLo] = src1Ry;
            ctrl[src2SelBit] = 1'b1;
            inst[ryHi:ryLo] = i[2:0];
            inst[rzHi:rzLo] = i[2:0];
            requestCheck();
        end
    endtask

    task automatic writeThenRead();
        regIdxT lastWrite;
        for (int n = 0; n < 48; n++) begin
            startCycle();
            regWrite = 1'b1;
            forwardA = fwdReg;
            forwardB = fwdReg;
            if (n % 8 == 0) begin
                writeReg = zeroReg;          // Must be dropped
            end
            lastWrite = writeReg;
            requestCheck();
            startCycle();
            regWrite = 1'b0;
            forwardA = fwdReg;
            forwardB = fwdReg;
            ctrl[src1SelHi:src1SelLo] = src1Ry;
            ctrl[src2SelBit] = 1'b1;
            inst[ryHi:ryLo] = lastWrite;
            requestCheck();
        end
    endtask

    task automatic forwardingSweep();
        for (int round = 0; round < 2; round++) begin
            for (int a = 0; a < 4; a++) begin
                for (int b = 0; b < 4; b++) begin
                    startCycle();
                    forwardA = fwdSelT'(a[1:0]);
                    forwardB = fwdSelT'(b[1:0]);
                    requestCheck();
                end
            end
        end
    endtask

    task automatic fieldSelectSweep();
        for (int c = 0; c < 64; c++) begin
            startCycle();
            ctrl = c[5:0];                   // Every control combination
            requestCheck();
        end
    endtask

    task automatic immediateAndTargets();
        for (int n = 0; n < 64; n++) begin
            startCycle();
            ctrl[extUpperBit] = n[0];
            ctrl[extSignedBit] = n[1];
            requestCheck();
        end
    endtask

    task automatic signedCompare();
        for (int n = 0; n < 16; n++) begin
            for (int k = 0; k < 3; k++) begin
                startCycle();
                forwardA = fwdExe;
                forwardB = fwdMem;
                if (k == 0) begin
                    dataMem = aluResultExe;
                end else if (k == 1) begin
                    dataMem = aluResultExe ^ 16'h8000;   // Sign bit only
                end
                requestCheck();
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        regWrite = 1'b0;
        ctrl = '0;
        forwardA = fwdReg;
        forwardB = fwdReg;
        inst = '0;
        pc = '0;
        aluResultExe = '0;
        dataMem = '0;
        dataWb = '0;
        writeReg = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        resetReadback();
        writeThenRead();
        forwardingSweep();
        fieldSelectSweep();
        immediateAndTargets();
        signedCompare();
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== decodeStage.f ====
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/instFields.sv
rtl/regFile.sv
rtl/operandForward.sv
rtl/decodeStage.sv
bench/decodeStage_props.sv
bench/decodeStageTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f decodeStage.f \
    --top-module decodeStageTb \
    -Mdir obj_dir -o simDecode
status=$?
if [ $status -ne 0 ]; then
    echo "FAIL: Verilator build returned status $status"
    exit 1
fi

./obj_dir/simDecode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "FAIL: simulation returned status $status"
    exit 1
fi

if grep -qx "All checks passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL: pass message not found in sim.log"
    exit 1
fi
